// ==== all.f ====
+incdir+.
pic_pkg.sv
pic_ctrl_if.sv
pic_regs.sv
irq_latch.sv
pic_ack_ctrl.sv
pic_top.sv
tb_pic.sv

// ==== irq_latch.sv ====
// Interrupt request capture
`timescale 1ns/10ps
`default_nettype none
`include "pic_settings.svh"

module irq_latch (
	input logic clk,
	input logic rst_n,
	input pic_pkg::irq_vec_t ir,
	input pic_pkg::irq_vec_t clr,
	output pic_pkg::irq_vec_t irr
);

	// Capture states, one machine per line
	typedef enum logic [1:0] {
		cap_idle, // Armed, waiting for ir high
		cap_active, // Request held
		cap_wait_low // Served, line must drop first
	} cap_state_t;

	genvar i;

	generate
		for (i = 0; i < `PIC_NUM_IRQ; i = i + 1) begin : g_line
			cap_state_t state;

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					state <= cap_idle;
				end else begin
					case (state)
						cap_idle: begin
							if (ir[i]) begin
								state <= cap_active; // Level seen
							end
						end
						cap_active: begin
							if (clr[i]) begin
								state <= cap_wait_low; // Acknowledged
							end
						end
						cap_wait_low: begin
							if (!ir[i]) begin
								state <= cap_idle; // Re-arm
							end
						end
						default: begin
							state <= cap_idle;
						end
					endcase
				end
			end

			assign irr[i] = (state == cap_active);
		end
	endgenerate

	// Core only clears lines it found pending
	assert property (@(posedge clk) disable iff (!rst_n) (clr & ~irr) == '0)
		else $error("irq_clr on a line with no request");

endmodule

`default_nettype wire

// ==== pic_ack_ctrl.sv ====
// PIC priority and acknowledge core
`timescale 1ns/10ps
`default_nettype none
`include "pic_settings.svh"

module pic_ack_ctrl (
	input logic clk,
	input logic rst_n,
	input logic inta_n,
	pic_ctrl_if.core ctrl,
	output pic_pkg::irq_vec_t irq_clr,
	output logic int_req,
	output pic_pkg::pic_data_t iid
);
	import pic_pkg::*;

	ack_state_t state;
	irq_vec_t pending; // Unmasked requests
	irq_vec_t win_bit; // Lowest pending line as one-hot
	irq_idx_t win_idx; // Index of that line
	logic ack; // Acknowledge taken this clock
	logic eoi_done; // EOI closes the current service

	assign pending = ctrl.irr & ~ctrl.imr;

	// Isolate lowest set bit
	assign win_bit = pending & (~pending + irq_vec_t'(1));

	// Scan from the top so lower lines override
	always_comb begin
		win_idx = '0;
		for (int n = `PIC_NUM_IRQ - 1; n >= 0; n--) begin
			if (pending[n]) begin
				win_idx = irq_idx_t'(n);
			end
		end
	end

	// inta_n only counts while int is up and something still pends
	assign ack = (state == ack_issue) && !inta_n && (pending != '0);
	assign eoi_done = (state == ack_wait_eoi) && ctrl.eoi;

	// Acknowledge FSM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ack_idle;
		end else begin
			case (state)
				ack_idle: begin
					if (pending != '0) begin
						state <= ack_issue; // Raise int next cycle
					end
				end
				ack_issue: begin
					if (ack) begin
						state <= ack_wait_eoi;
					end else if (pending == '0) begin
						state <= ack_idle; // Request masked away
					end
				end
				ack_wait_eoi: begin
					if (eoi_done) begin
						state <= ack_idle;
					end
				end
				default: begin
					state <= ack_idle;
				end
			endcase
		end
	end

	// In-service register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl.isr <= '0;
		end else if (ack) begin
			ctrl.isr <= win_bit;
		end else if (eoi_done) begin
			ctrl.isr <= '0; // Service finished
		end
	end

	// Clear pulse back to the capture machines
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_clr <= '0;
		end else begin
			irq_clr <= ack ? win_bit : '0; // One cycle only
		end
	end

	// Vector latch held until the next acknowledge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			iid <= '0;
		end else if (ack) begin
			iid <= pic_data_t'(`PIC_VECTOR_BASE) + pic_data_t'(win_idx);
		end
	end

	assign int_req = (state == ack_issue);

	// At most one line in service and it is the line named by iid
	assert property (@(posedge clk) disable iff (!rst_n)
		(ctrl.isr == '0) ||
		(ctrl.isr == (irq_vec_t'(1) << irq_idx_t'(iid - pic_data_t'(`PIC_VECTOR_BASE)))))
		else $error("isr not the one-hot bit of iid");

	// New requests wait for EOI before int comes back
	assert property (@(posedge clk) disable iff (!rst_n) (ctrl.isr != '0) |-> !int_req)
		else $error("int_req raised while a line is in service");

endmodule

`default_nettype wire

// ==== pic_ctrl_if.sv ====
// PIC register to core link
`timescale 1ns/10ps
`default_nettype none

interface pic_ctrl_if;
	import pic_pkg::*;

	irq_vec_t imr; // Mask, set bit blocks the line
	logic eoi; // One-cycle end-of-interrupt strobe
	irq_vec_t irr; // Latched requests, from the capture machines
	irq_vec_t isr; // Line currently served, one-hot

	// Host side
	modport regs (
		output imr,
		output eoi,
		input irr,
		input isr
	);

	// Priority and acknowledge side
	modport core (
		input imr,
		input eoi,
		input irr,
		output isr
	);

endinterface

`default_nettype wire

// ==== pic_pkg.sv ====
// PIC shared types
`default_nettype none
`include "pic_settings.svh"

package pic_pkg;

	// One bit per interrupt line
	typedef logic [`PIC_NUM_IRQ-1:0] irq_vec_t; // Request, mask, in-service

	typedef logic [`PIC_IDX_W-1:0] irq_idx_t; // Line number

	// Host byte, also the acknowledge vector
	typedef logic [`PIC_DATA_W-1:0] pic_data_t;

	typedef logic [1:0] rd_sel_t; // IRR or ISR read code

	// Acknowledge sequence
	typedef enum logic [1:0] {
		ack_idle, // Nothing pending
		ack_issue, // int raised, waiting for inta_n
		ack_wait_eoi // Line in service until EOI
	} ack_state_t;

endpackage

`default_nettype wire

// ==== pic_regs.sv ====
// PIC host registers
`timescale 1ns/10ps
`default_nettype none
`include "pic_settings.svh"

module pic_regs (
	input logic clk,
	input logic rst_n,
	input logic cs_n,
	input logic wr_n,
	input logic rd_n,
	input logic a0,
	input pic_pkg::pic_data_t d_in,
	output pic_pkg::pic_data_t d_out,
	pic_ctrl_if.regs ctrl
);
	import pic_pkg::*;

	logic wr_en; // Host write this clock
	logic rd_en; // Host read in progress
	logic cmd_eoi; // Command write decodes as EOI
	logic cmd_rdsel; // Command write decodes as read select
	rd_sel_t rd_sel; // Which register an a0 low read returns
	irq_vec_t rd_reg; // Register picked by read select

	// Plain strobes with no handshake
	assign wr_en = ~cs_n & ~wr_n;
	assign rd_en = ~cs_n & ~rd_n;

	// a0 low writes carry a command in d_in[4:3]
	assign cmd_eoi = wr_en & ~a0 & (d_in[4:3] == `PIC_CMD_EOI);
	assign cmd_rdsel = wr_en & ~a0 & (d_in[4:3] == `PIC_CMD_RDSEL);
	// Bit 4 set matches neither and the write is dropped

	// Mask register written with a0 high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl.imr <= '0; // All lines enabled
		end else if (wr_en && a0) begin
			ctrl.imr <= irq_vec_t'(d_in);
		end
	end

	// EOI strobe seen by the core one cycle after the write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl.eoi <= 1'b0;
		end else begin
			ctrl.eoi <= cmd_eoi;
		end
	end

	// Read select
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_sel <= `PIC_RD_IRR; // Requests visible by default
		end else if (cmd_rdsel) begin
			rd_sel <= d_in[1:0];
		end
	end

	assign rd_reg = (rd_sel == `PIC_RD_ISR) ? ctrl.isr : ctrl.irr;

	// Combinational read mux while cs_n and rd_n are low
	always_comb begin
		if (!rd_en) begin
			d_out = '0; // Bus idle
		end else if (a0) begin
			d_out = pic_data_t'(ctrl.imr);
		end else begin
			d_out = pic_data_t'(rd_reg); // IRR or ISR
		end
	end

	// A held command write would stretch EOI past a single service
	assert property (@(posedge clk) disable iff (!rst_n) ctrl.eoi |=> !ctrl.eoi)
		else $error("eoi high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== pic_settings.svh ====
// PIC build settings
`ifndef PIC_SETTINGS_SVH
`define PIC_SETTINGS_SVH

// Line count and bus widths
`define PIC_NUM_IRQ 8
`define PIC_DATA_W 8
`define PIC_IDX_W 3 // log2 of line count

// Acknowledge vector is base plus winning line index
`define PIC_VECTOR_BASE 8'h08

// Command field, d_in[4:3] of an a0 low write
`define PIC_CMD_EOI 2'b00 // End of interrupt
`define PIC_CMD_RDSEL 2'b01 // Read select
// Codes with bit 4 set are not decoded

// Read-select codes, d_in[1:0] of a read-select command
`define PIC_RD_IRR 2'b10 // Request register
`define PIC_RD_ISR 2'b11 // In-service register

`endif

// ==== pic_top.sv ====
// PIC top level
`timescale 1ns/10ps
`default_nettype none
`include "pic_settings.svh"

module pic_top (
	input logic clk,
	input logic rst_n,
	input logic cs_n,
	input logic wr_n,
	input logic rd_n,
	input logic a0,
	input logic inta_n,
	input logic [`PIC_DATA_W-1:0] d_in,
	input logic [`PIC_NUM_IRQ-1:0] ir,
	output logic [`PIC_DATA_W-1:0] d_out,
	output logic int_out,
	output logic spen_n,
	output logic [`PIC_DATA_W-1:0] iid
);
	import pic_pkg::*;

	irq_vec_t irr; // Latched requests
	irq_vec_t irq_clr; // Acknowledge clear, one-hot pulse

	pic_ctrl_if ctrl_if ();

	assign ctrl_if.irr = irr; // Latches feed both sides
	assign spen_n = cs_n | rd_n; // Low only while the host reads

	// Mask, commands and read mux
	pic_regs regs_inst (
		.clk (clk),
		.rst_n (rst_n),
		.cs_n (cs_n),
		.wr_n (wr_n),
		.rd_n (rd_n),
		.a0 (a0),
		.d_in (d_in),
		.d_out (d_out),
		.ctrl (ctrl_if.regs)
	);

	// Per-line capture
	irq_latch latch_inst (
		.clk (clk),
		.rst_n (rst_n),
		.ir (ir),
		.clr (irq_clr),
		.irr (irr)
	);

	// Priority, acknowledge and vector
	pic_ack_ctrl ack_inst (
		.clk (clk),
		.rst_n (rst_n),
		.inta_n (inta_n),
		.ctrl (ctrl_if.core),
		.irq_clr (irq_clr),
		.int_req (int_out),
		.iid (iid)
	);

endmodule

`default_nettype wire

// ==== tb_pic.sv ====
// PIC testbench
`timescale 1ns/10ps
`default_nettype none
`include "pic_settings.svh"

module tb_pic;
	import pic_pkg::*;

	logic clk;
	logic rst_n;
	logic cs_n;
	logic wr_n;
	logic rd_n;
	logic a0;
	logic inta_n;
	pic_data_t d_in;
	irq_vec_t ir;
	pic_data_t d_out;
	logic int_out;
	logic spen_n;
	pic_data_t iid;

	integer seed = 32'hfa24_cd42; // Fixed stimulus seed
	integer err_count = 0;
	integer chk_count = 0;
	integer tests_done = 0;
	integer test_err_base = 0; // Errors before the current test

	irq_vec_t shadow_imr; // Model copy of the mask
	irq_vec_t shadow_req; // Model copy of latched requests

	string name_q[$]; // Pending compares
	pic_data_t got_q[$];
	pic_data_t exp_q[$];
	string cmp_name;
	pic_data_t cmp_got;
	pic_data_t cmp_exp;

	pic_data_t r;
	pic_data_t rd_data;
	logic rd_spen;
	logic seen;
	irq_idx_t idx_a;
	irq_idx_t idx_b;

	pic_top pic_top_inst (
		.clk (clk),
		.rst_n (rst_n),
		.cs_n (cs_n),
		.wr_n (wr_n),
		.rd_n (rd_n),
		.a0 (a0),
		.inta_n (inta_n),
		.d_in (d_in),
		.ir (ir),
		.d_out (d_out),
		.int_out (int_out),
		.spen_n (spen_n),
		.iid (iid)
	);

	always #5 clk = ~clk; // 10 ns period

	// Vector of the lowest unmasked request or 0 when nothing pends
	function automatic pic_data_t expect_vector(input irq_vec_t req, input irq_vec_t mask);
		irq_vec_t pend;
		pic_data_t vec;
		pend = req & ~mask;
		vec = '0;
		for (int n = 0; n < `PIC_NUM_IRQ; n++) begin
			if (pend[n] && vec == '0) begin
				vec = pic_data_t'(`PIC_VECTOR_BASE + n); // First hit wins
			end
		end
		return vec;
	endfunction

	// Compare process draining whatever the tasks queued
	always @(posedge clk) begin
		while (name_q.size() > 0) begin
			cmp_name = name_q.pop_front();
			cmp_got = got_q.pop_front();
			cmp_exp = exp_q.pop_front();
			chk_count++;
			if (cmp_got !== cmp_exp) begin
				$display("error %s: got 0x%02h expected 0x%02h", cmp_name, cmp_got, cmp_exp);
				err_count++;
			end
		end
	end

	task push_check(input string name, input pic_data_t got, input pic_data_t exp);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	task host_write(input logic addr, input pic_data_t data);
		@(negedge clk);
		cs_n = 1'b0;
		wr_n = 1'b0;
		a0 = addr;
		d_in = data;
		@(negedge clk);
		cs_n = 1'b1; // Single write strobe
		wr_n = 1'b1;
	endtask

	task host_read(input logic addr, output pic_data_t data, output logic spen);
		@(negedge clk);
		cs_n = 1'b0;
		rd_n = 1'b0;
		a0 = addr;
		#2; // Mux settled well before the next edge
		data = d_out;
		spen = spen_n;
		@(negedge clk);
		cs_n = 1'b1;
		rd_n = 1'b1;
	endtask

	task set_read_sel(input rd_sel_t code);
		host_write(1'b0, {3'b000, `PIC_CMD_RDSEL, 1'b0, code});
	endtask

	task send_eoi();
		host_write(1'b0, {3'b000, `PIC_CMD_EOI, 3'b000});
	endtask

	// One-cycle level on the chosen lines
	task pulse_ir(input irq_vec_t lines);
		@(negedge clk);
		ir = lines;
		shadow_req = shadow_req | lines;
		@(negedge clk);
		ir = '0;
	endtask

	task acknowledge();
		@(negedge clk);
		inta_n = 1'b0;
		@(negedge clk);
		inta_n = 1'b1; // Sampled low on exactly one edge
	endtask

	task wait_int_high();
		int t;
		t = 0;
		while (int_out !== 1'b1 && t < 50) begin
			@(negedge clk);
			t++;
		end
		if (int_out !== 1'b1) begin
			$display("timeout: int_out did not rise within 50 cycles");
			err_count++;
		end
	endtask

	// Reports whether int_out rose at all in a fixed window
	task watch_int(input int cycles, output logic hit);
		hit = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			hit = hit | int_out;
		end
	endtask

	// Wait for int, take the acknowledge, compare the vector
	task service_one();
		pic_data_t exp;
		wait_int_high();
		exp = expect_vector(shadow_req, shadow_imr);
		acknowledge();
		push_check("iid", iid, exp);
		if (exp != '0) begin
			shadow_req[irq_idx_t'(exp - `PIC_VECTOR_BASE)] = 1'b0; // Served line leaves the model
		end
	endtask

	task service_all();
		for (int k = 0; k < `PIC_NUM_IRQ && (shadow_req & ~shadow_imr) != '0; k++) begin
			service_one();
			send_eoi();
		end
	endtask

	task finish_test(input string name);
		int t;
		t = 0;
		while (name_q.size() > 0 && t < 20) begin
			@(negedge clk);
			t++;
		end
		if (name_q.size() > 0) begin
			$display("compare queue did not drain in test %s", name);
			err_count++;
			name_q.delete();
			got_q.delete();
			exp_q.delete();
		end
		tests_done++;
		$display("test %-14s %s (%0d errors)", name,
			(err_count == test_err_base) ? "pass" : "fail", err_count - test_err_base);
		test_err_base = err_count;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		cs_n = 1'b1;
		wr_n = 1'b1;
		rd_n = 1'b1;
		a0 = 1'b0;
		inta_n = 1'b1;
		d_in = '0;
		ir = '0;
		shadow_imr = '0;
		shadow_req = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		// Reset values
		push_check("int_out", int_out, 8'h00);
		push_check("iid", iid, 8'h00);
		push_check("spen_n", spen_n, 8'h01); // No read yet
		host_read(1'b1, rd_data, rd_spen);
		push_check("d_out", rd_data, 8'h00);
		finish_test("reset");

		// Mask read-back
		repeat (4) begin
			r = $random(seed);
			host_write(1'b1, r);
			shadow_imr = r;
			host_read(1'b1, rd_data, rd_spen);
			push_check("d_out", rd_data, shadow_imr);
			push_check("spen_n", rd_spen, 8'h00);
		end
		host_write(1'b1, 8'h00);
		shadow_imr = '0;
		finish_test("mask_readback");

		// Single line through ack and EOI
		r = $random(seed);
		idx_a = r[2:0];
		pulse_ir(irq_vec_t'(1) << idx_a);
		service_one();
		set_read_sel(`PIC_RD_ISR);
		host_read(1'b0, rd_data, rd_spen);
		push_check("d_out", rd_data, irq_vec_t'(1) << idx_a); // One-hot ISR
		send_eoi();
		host_read(1'b0, rd_data, rd_spen);
		push_check("d_out", rd_data, 8'h00);
		set_read_sel(`PIC_RD_IRR);
		finish_test("single_irq");

		// Several lines at once served lowest first
		r = $random(seed);
		if ($countones(r) < 2) begin
			r = r | 8'h82;
		end
		pulse_ir(r);
		service_all();
		finish_test("priority");

		// Masked lines stay quiet but still latch
		r = $random(seed);
		if (r == '0) begin
			r = 8'h24;
		end
		host_write(1'b1, r);
		shadow_imr = r;
		pulse_ir(r);
		watch_int(10, seen);
		push_check("int_out", seen, 8'h00);
		host_read(1'b0, rd_data, rd_spen);
		push_check("d_out", rd_data, shadow_req);
		host_write(1'b1, 8'h00); // Unmask then drain
		shadow_imr = '0;
		service_all();
		finish_test("masking");

		// Request during service waits for EOI
		r = $random(seed);
		idx_a = r[2:0];
		idx_b = idx_a + ((r[5:3] == 3'd0) ? 3'd1 : r[5:3]); // Always a different line
		pulse_ir(irq_vec_t'(1) << idx_a);
		service_one();
		pulse_ir(irq_vec_t'(1) << idx_b);
		watch_int(8, seen);
		push_check("int_out", seen, 8'h00);
		send_eoi();
		service_one();
		send_eoi();
		finish_test("back_pressure");

		$display("%0d tests, %0d checks, %0d errors", tests_done, chk_count, err_count);
		if (err_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
